//--- lcd_defines.svh
`ifndef LCD_DEFINES_SVH
`define LCD_DEFINES_SVH

// bus timing, all in i_clk cycles

// rs and data settle before en rises
`define LCD_SETUP 1

// en pulse width
`define LCD_EN_HIGH 4

// execution time after en falls
`define LCD_EXEC_WAIT 20

// whole phase sequence of one transaction after the start cycle
`define LCD_TXN_CYCLES (`LCD_SETUP + `LCD_EN_HIGH + `LCD_EXEC_WAIT)

// panel geometry
`define LCD_COLS 16            // characters per line
`define LCD_LINE2_ADDR 7'h40   // ddram address of line 2, column 0

// power-up sequence length
`define LCD_INIT_CMDS 5

`endif

//--- lcd_pkg.sv
package lcd_pkg;

    // one byte on the lcd data bus
    typedef logic [7:0] lcd_byte_t;

    // ddram address
    typedef logic [6:0] lcd_addr_t;

    // character index over both lines, 0 to 31
    typedef logic [4:0] lcd_col_t;

    // message select
    typedef logic [2:0] lcd_mode_t;

    // command type for the command engine
    // 0 to 4 are the init commands, 5 sets the ddram address
    typedef logic [2:0] lcd_cmd_t;

    localparam lcd_cmd_t CMD_SET_ADDR = 3'd5;

    // pins seen by the panel, rw is tied low on the board
    typedef struct packed {
        logic      rs;    // 0 command, 1 data
        logic      en;
        lcd_byte_t data;
    } lcd_bus_t;

    // top level sequencer
    typedef enum logic [2:0] {
        S_BEGIN,
        S_INIT,
        S_IDLE,
        S_SET_ADDR,
        S_WRITE
    } lcd_state_e;

endpackage

//--- lcd_msg_rom.sv
`timescale 1ns/1ps

module lcd_msg_rom
    import lcd_pkg::*;
(
    input  lcd_mode_t i_mode,
    input  lcd_col_t  i_col,
    output lcd_byte_t o_char
);

    // words packed msb first, upper bytes stay zero
    localparam logic [71:0] W_STOP = "stop";
    localparam logic [71:0] W_PAUSE = "pause";
    localparam logic [71:0] W_PLAYING = "playing";
    localparam logic [71:0] W_RECORDING = "recording";
    localparam logic [71:0] W_MODE = "mode ";

    localparam lcd_byte_t SPACE = 8'h20;

    lcd_byte_t line1_ch;
    lcd_byte_t line2_ch;
    lcd_byte_t digit;

    // character idx of a left-aligned word, space past its end
    function automatic lcd_byte_t word_char(input logic [71:0] word,
                                            input int unsigned len,
                                            input logic [3:0]  idx);
        lcd_byte_t ch;
        ch = SPACE;
        if (idx < len) begin
            ch = word[8*(len-1-idx) +: 8];
        end
        return ch;
    endfunction

    assign digit = 8'h30 + {5'd0, i_mode}; // ascii '0' + mode

    always_comb begin
        case (i_mode)
            3'd0:    line1_ch = word_char(W_STOP, 4, i_col[3:0]);
            3'd1:    line1_ch = word_char(W_PAUSE, 5, i_col[3:0]);
            3'd2:    line1_ch = word_char(W_PLAYING, 7, i_col[3:0]);
            default: line1_ch = word_char(W_RECORDING, 9, i_col[3:0]); // 3 to 7
        endcase
    end

    always_comb begin
        if (i_col[3:0] == 4'd5) begin
            line2_ch = digit;  // right after "mode "
        end else begin
            line2_ch = word_char(W_MODE, 5, i_col[3:0]);
        end
    end

    // upper half of the index is line 2
    assign o_char = i_col[4] ? line2_ch : line1_ch;

endmodule

//--- lcd_cmd_engine.sv
`timescale 1ns/1ps
`include "lcd_defines.svh"

module lcd_cmd_engine
    import lcd_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_start,
    input  lcd_cmd_t  i_type,
    input  lcd_addr_t i_addr,
    output lcd_bus_t  o_bus,
    output logic      o_finish
);

    localparam int CNT_W = $clog2(`LCD_TXN_CYCLES + 1);
    localparam logic [CNT_W-1:0] EN_ON = CNT_W'(`LCD_SETUP);
    localparam logic [CNT_W-1:0] EN_OFF = CNT_W'(`LCD_SETUP + `LCD_EN_HIGH);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(`LCD_TXN_CYCLES - 1);

    logic             busy;
    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] cnt_nxt;
    lcd_byte_t        opcode;

    always_comb begin
        case (i_type)
            3'd0:         opcode = 8'h38;           // 8-bit bus, 2 lines, 5x8
            3'd1:         opcode = 8'h0C;           // display on, no cursor
            3'd2:         opcode = 8'h01;           // clear
            3'd3:         opcode = 8'h06;           // increment, no shift
            3'd4:         opcode = 8'h02;           // return home
            CMD_SET_ADDR: opcode = {1'b1, i_addr};  // 0x80 | ddram address
            default:      opcode = 8'h02;
        endcase
    end

    assign cnt_nxt = cnt + 1'b1;

    // cnt 0 is setup, then en high, then the execution wait
    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            busy     <= 1'b0;
            cnt      <= '0;
            o_bus    <= '0;
            o_finish <= 1'b0;
        end else begin
            o_finish <= 1'b0;
            if (i_start && !busy) begin
                busy       <= 1'b1;
                cnt        <= '0;
                o_bus.rs   <= 1'b0;
                o_bus.en   <= 1'b0;
                o_bus.data <= opcode;
            end else if (busy) begin
                cnt      <= cnt_nxt;
                o_bus.en <= (cnt_nxt >= EN_ON) && (cnt_nxt < EN_OFF);
                if (cnt == LAST) begin
                    busy     <= 1'b0;
                    o_finish <= 1'b1;
                end
            end
        end
    end

endmodule

//--- lcd_data_engine.sv
`timescale 1ns/1ps
`include "lcd_defines.svh"

module lcd_data_engine
    import lcd_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_start,
    input  lcd_byte_t i_char,
    output lcd_bus_t  o_bus,
    output logic      o_finish
);

    localparam int CNT_W = $clog2(`LCD_TXN_CYCLES + 1);
    localparam logic [CNT_W-1:0] EN_ON = CNT_W'(`LCD_SETUP);
    localparam logic [CNT_W-1:0] EN_OFF = CNT_W'(`LCD_SETUP + `LCD_EN_HIGH);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(`LCD_TXN_CYCLES - 1);

    logic             busy;
    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] cnt_nxt;

    assign cnt_nxt = cnt + 1'b1;

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            busy     <= 1'b0;
            cnt      <= '0;
            o_bus    <= '0;
            o_finish <= 1'b0;
        end else begin
            o_finish <= 1'b0;
            if (i_start && !busy) begin
                busy       <= 1'b1;
                cnt        <= '0;
                o_bus.rs   <= 1'b1;   // ddram write
                o_bus.en   <= 1'b0;
                o_bus.data <= i_char; // held until the next write
            end else if (busy) begin
                cnt      <= cnt_nxt;
                o_bus.en <= (cnt_nxt >= EN_ON) && (cnt_nxt < EN_OFF);
                if (cnt == LAST) begin
                    busy     <= 1'b0;
                    o_finish <= 1'b1;
                end
            end
        end
    end

endmodule

//--- lcd_ctrl.sv
`timescale 1ns/1ps
`include "lcd_defines.svh"

module lcd_ctrl
    import lcd_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_start,
    input  lcd_mode_t i_mode,
    output lcd_bus_t  o_lcd,
    output logic      o_init_done
);

    localparam lcd_cmd_t INIT_LAST = lcd_cmd_t'(`LCD_INIT_CMDS - 1);
    localparam lcd_col_t COL_EOL1 = lcd_col_t'(`LCD_COLS - 1);
    localparam lcd_col_t COL_LAST = lcd_col_t'(2 * `LCD_COLS - 1);

    lcd_state_e state_r, state_w;
    lcd_cmd_t   init_idx_r, init_idx_w;
    lcd_col_t   col_r, col_w;
    lcd_mode_t  mode_r, mode_w;
    logic       cmd_start_r, cmd_start_w;
    lcd_cmd_t   cmd_type_r, cmd_type_w;
    lcd_addr_t  cmd_addr_r, cmd_addr_w;
    logic       data_start_r, data_start_w;

    lcd_bus_t  cmd_bus;
    lcd_bus_t  data_bus;
    logic      cmd_finish;
    logic      data_finish;
    lcd_byte_t rom_char;
    logic      cmd_sel;

    lcd_msg_rom u_msg_rom (
        .i_mode (mode_r),
        .i_col  (col_r),
        .o_char (rom_char)
    );

    lcd_cmd_engine u_cmd_engine (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_start  (cmd_start_r),
        .i_type   (cmd_type_r),
        .i_addr   (cmd_addr_r),
        .o_bus    (cmd_bus),
        .o_finish (cmd_finish)
    );

    // rom output is latched by the engine on data_start
    lcd_data_engine u_data_engine (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_start  (data_start_r),
        .i_char   (rom_char),
        .o_bus    (data_bus),
        .o_finish (data_finish)
    );

    assign cmd_sel = (state_r == S_BEGIN) || (state_r == S_INIT) || (state_r == S_SET_ADDR);
    assign o_lcd = cmd_sel ? cmd_bus : data_bus;
    assign o_init_done = (state_r == S_IDLE);

    always_comb begin
        state_w      = state_r;
        init_idx_w   = init_idx_r;
        col_w        = col_r;
        mode_w       = mode_r;
        cmd_start_w  = 1'b0;       // starts are single-cycle pulses
        cmd_type_w   = cmd_type_r;
        cmd_addr_w   = cmd_addr_r;
        data_start_w = 1'b0;
        case (state_r)
            S_BEGIN: begin
                init_idx_w  = '0;
                cmd_type_w  = '0;
                cmd_start_w = 1'b1;
                state_w     = S_INIT;
            end
            S_INIT: begin
                if (cmd_finish) begin
                    if (init_idx_r == INIT_LAST) begin
                        state_w = S_IDLE;
                    end else begin
                        init_idx_w  = init_idx_r + 1'b1;
                        cmd_type_w  = init_idx_r + 1'b1;
                        cmd_start_w = 1'b1;
                    end
                end
            end
            S_IDLE: begin
                if (i_start) begin
                    mode_w      = i_mode;  // held for the whole refresh
                    col_w       = '0;
                    cmd_type_w  = CMD_SET_ADDR;
                    cmd_addr_w  = '0;
                    cmd_start_w = 1'b1;
                    state_w     = S_SET_ADDR;
                end
            end
            S_SET_ADDR: begin
                if (cmd_finish) begin
                    data_start_w = 1'b1;
                    state_w      = S_WRITE;
                end
            end
            S_WRITE: begin
                if (data_finish) begin
                    if (col_r == COL_LAST) begin
                        state_w = S_IDLE;
                    end else if (col_r == COL_EOL1) begin
                        // jump to line 2 before column 16
                        col_w       = col_r + 1'b1;
                        cmd_type_w  = CMD_SET_ADDR;
                        cmd_addr_w  = `LCD_LINE2_ADDR;
                        cmd_start_w = 1'b1;
                        state_w     = S_SET_ADDR;
                    end else begin
                        col_w        = col_r + 1'b1;
                        data_start_w = 1'b1;
                    end
                end
            end
            default: state_w = S_BEGIN;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_r      <= S_BEGIN;
            init_idx_r   <= '0;
            col_r        <= '0;
            mode_r       <= '0;
            cmd_start_r  <= 1'b0;
            cmd_type_r   <= '0;
            cmd_addr_r   <= '0;
            data_start_r <= 1'b0;
        end else begin
            state_r      <= state_w;
            init_idx_r   <= init_idx_w;
            col_r        <= col_w;
            mode_r       <= mode_w;
            cmd_start_r  <= cmd_start_w;
            cmd_type_r   <= cmd_type_w;
            cmd_addr_r   <= cmd_addr_w;
            data_start_r <= data_start_w;
        end
    end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    input  logic i_rst_req,
    output logic o_clk,
    output logic o_rst_n
);

    logic [2:0] por_cnt = 3'd4;  // power-on reset length in cycles

    initial begin
        o_clk = 1'b0;
        forever #4 o_clk = ~o_clk;  // 8 ns period
    end

    // counts down on falling edges so reset releases away from the DUT's edge
    always @(negedge o_clk) begin
        if (por_cnt != 3'd0) begin
            por_cnt <= por_cnt - 3'd1;
        end
    end

    assign o_rst_n = (por_cnt != 3'd0) || i_rst_req;  // active high

endmodule

//--- lcd_assertions.sv
`timescale 1ns/1ps
`include "lcd_defines.svh"

module lcd_assertions
    import lcd_pkg::*;
(
    input logic     i_clk,
    input logic     i_rst_n,
    input logic     i_start,
    input lcd_bus_t i_lcd,
    input logic     i_init_done
);

    int unsigned high_cnt;  // length of the current en pulse

    always @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            high_cnt <= 0;
        end else if (i_lcd.en) begin
            high_cnt <= high_cnt + 1;
        end else begin
            high_cnt <= 0;
        end
    end

    a_en_width: assert property (@(posedge i_clk) disable iff (i_rst_n)
        $fell(i_lcd.en) |-> (high_cnt == `LCD_EN_HIGH))
        else $error("en pulse lasted %0d cycles", high_cnt);

    a_en_max: assert property (@(posedge i_clk) disable iff (i_rst_n)
        i_lcd.en |-> (high_cnt < `LCD_EN_HIGH))
        else $error("en pulse longer than %0d cycles", `LCD_EN_HIGH);

    // rs and data settle during setup, so they match the previous cycle too
    a_bus_stable: assert property (@(posedge i_clk) disable iff (i_rst_n)
        i_lcd.en |-> $stable({i_lcd.rs, i_lcd.data}))
        else $error("rs or data changed while en was high");

    a_done_fall: assert property (@(posedge i_clk) disable iff (i_rst_n)
        $fell(i_init_done) |-> $past(i_start))
        else $error("o_init_done fell without i_start");

endmodule

//--- tb_lcd.sv
`timescale 1ns/1ps
`include "lcd_defines.svh"

module tb_lcd
    import lcd_pkg::*;
();

    localparam int N_ROWS = 7;
    localparam int TXN = 1 + `LCD_TXN_CYCLES;          // cycles per bus write
    localparam int REFRESH_TXNS = 2 * `LCD_COLS + 2;
    localparam int INIT_TIMEOUT = 400;
    localparam int REFRESH_TIMEOUT = 2000;
    localparam lcd_byte_t INIT_BYTES [`LCD_INIT_CMDS] = '{8'h38, 8'h0C, 8'h01, 8'h06, 8'h02};

    logic      clk;
    logic      rst_n;
    logic      rst_req;
    logic      start;
    lcd_mode_t mode;
    lcd_bus_t  lcd;
    logic      init_done;

    logic [8:0] seen_q[$];  // {rs, data} per en fall
    logic [8:0] exp_q[$];
    logic       prev_en;
    int         seed;

    // stimulus table
    lcd_mode_t tbl_mode [N_ROWS];
    int        tbl_delay [N_ROWS];
    string     tbl_word [N_ROWS];
    bit        tbl_chg_mode [N_ROWS];
    bit        tbl_restart [N_ROWS];
    bit        tbl_reset [N_ROWS];

    tb_clk_gen u_clk_gen (
        .i_rst_req (rst_req),
        .o_clk     (clk),
        .o_rst_n   (rst_n)
    );

    lcd_ctrl u_lcd_ctrl (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_start     (start),
        .i_mode      (mode),
        .o_lcd       (lcd),
        .o_init_done (init_done)
    );

    bind lcd_ctrl lcd_assertions u_lcd_assertions (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_lcd       (o_lcd),
        .i_init_done (o_init_done)
    );

    // bus monitor, one entry per falling en
    always @(negedge clk) begin
        if (rst_n) begin
            prev_en <= 1'b0;
        end else begin
            if (prev_en && !lcd.en) begin
                seen_q.push_back({lcd.rs, lcd.data});
            end
            prev_en <= lcd.en;
        end
    end

    task automatic report_error(input string line);
        $display("%s", line);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        report_error($sformatf("** Error: %s expected 0x%0h got 0x%0h", name, expected, actual));
    endtask

    function automatic string word_for_mode(input lcd_mode_t m);
        case (m)
            3'd0:    return "stop";
            3'd1:    return "pause";
            3'd2:    return "playing";
            default: return "recording";
        endcase
    endfunction

    task automatic set_row(input int r, input lcd_mode_t m, input int delay, input string word,
                           input bit chg, input bit restart, input bit rst);
        tbl_mode[r] = m;
        tbl_delay[r] = delay;
        tbl_word[r] = word;
        tbl_chg_mode[r] = chg;
        tbl_restart[r] = restart;
        tbl_reset[r] = rst;
    endtask

    task automatic load_table();
        logic [31:0] rnd;
        seed = 40;
        rnd = $random(seed);
        set_row(0, 3'd0, 3, "stop", 1'b0, 1'b0, 1'b0);
        set_row(1, 3'd1, 0, "pause", 1'b1, 1'b0, 1'b0);
        set_row(2, 3'd2, 7, "playing", 1'b0, 1'b1, 1'b0);
        set_row(3, 3'd3, 1, "recording", 1'b1, 1'b1, 1'b0);
        set_row(4, 3'd7, 5, "recording", 1'b0, 1'b0, 1'b0);
        set_row(5, rnd[2:0], int'(rnd[7:4]), word_for_mode(rnd[2:0]), 1'b1, 1'b0, 1'b0);
        set_row(6, 3'd2, 2, "playing", 1'b0, 1'b0, 1'b1);
    endtask

    // 0x80, line 1, 0xC0, line 2
    task automatic build_expected(input string word, input lcd_mode_t m);
        int        c;
        lcd_byte_t ch;
        string     line2;
        line2 = "mode ";
        exp_q.delete();
        exp_q.push_back({1'b0, 8'h80});
        for (c = 0; c < `LCD_COLS; c++) begin
            ch = (c < word.len()) ? word[c] : 8'h20;
            exp_q.push_back({1'b1, ch});
        end
        exp_q.push_back({1'b0, 8'hC0});
        for (c = 0; c < `LCD_COLS; c++) begin
            if (c < line2.len()) begin
                ch = line2[c];
            end else if (c == line2.len()) begin
                ch = "0" + lcd_byte_t'(m);
            end else begin
                ch = 8'h20;
            end
            exp_q.push_back({1'b1, ch});
        end
    endtask

    task automatic wait_init_level(input logic level, input int limit);
        int n;
        n = 0;
        while (init_done !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert (init_done === level)
            else report_error($sformatf("timeout: o_init_done did not reach %0b in %0d cycles",
                                        level, limit));
    endtask

    task automatic wait_en_high(input int limit);
        int n;
        n = 0;
        while (lcd.en !== 1'b1 && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert (lcd.en === 1'b1)
            else report_error("timeout: en never went high during the refresh");
    endtask

    task automatic wait_reset_release(input int limit);
        int n;
        n = 0;
        while (rst_n && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert (!rst_n) else report_error("timeout: reset was never released");
    endtask

    task automatic check_reset_state();
        assert (lcd.en == 1'b0) else report_mismatch("o_lcd.en", 0, lcd.en);
        assert (lcd.data == 8'h00) else report_mismatch("o_lcd.data", 0, lcd.data);
        assert (init_done == 1'b0) else report_mismatch("o_init_done", 0, init_done);
    endtask

    task automatic check_init_sequence();
        int i;
        wait_init_level(1'b1, INIT_TIMEOUT);
        assert (seen_q.size() == `LCD_INIT_CMDS)
            else report_error($sformatf("init wrote %0d bytes before o_init_done, expected %0d",
                                        seen_q.size(), `LCD_INIT_CMDS));
        for (i = 0; i < `LCD_INIT_CMDS; i++) begin
            assert (seen_q[i] == {1'b0, INIT_BYTES[i]})
                else report_mismatch($sformatf("init write %0d {o_lcd.rs, o_lcd.data}", i),
                                     {1'b0, INIT_BYTES[i]}, seen_q[i]);
        end
    endtask

    task automatic apply_reset();
        rst_req = 1'b1;
        @(negedge clk);
        seen_q.delete();
        check_reset_state();
        repeat (3) @(negedge clk);
        rst_req = 1'b0;
    endtask

    task automatic run_row(input int r);
        int i;
        seen_q.delete();
        build_expected(tbl_word[r], tbl_mode[r]);
        repeat (tbl_delay[r]) @(negedge clk);
        start = 1'b1;
        mode = tbl_mode[r];
        @(negedge clk);
        start = 1'b0;
        if (tbl_chg_mode[r]) begin
            mode = ~tbl_mode[r];  // must not reach this refresh
        end
        wait_init_level(1'b0, 4);
        if (tbl_restart[r]) begin
            repeat (3 * TXN) @(negedge clk);
            start = 1'b1;
            mode = tbl_mode[r] + 3'd1;
            @(negedge clk);
            start = 1'b0;
        end
        if (tbl_reset[r]) begin
            repeat (5 * TXN) @(negedge clk);
            wait_en_high(TXN + 2);  // hit the reset inside an en pulse
            apply_reset();
            check_init_sequence();
        end else begin
            wait_init_level(1'b1, REFRESH_TIMEOUT);
            repeat (2 * TXN) @(negedge clk);  // nothing more may follow
            assert (init_done) else report_mismatch("o_init_done", 1, init_done);
            assert (seen_q.size() == REFRESH_TXNS)
                else report_error($sformatf("row %0d: refresh wrote %0d bytes, expected %0d",
                                            r, seen_q.size(), REFRESH_TXNS));
            for (i = 0; i < REFRESH_TXNS; i++) begin
                assert (seen_q[i] == exp_q[i])
                    else report_mismatch($sformatf("row %0d write %0d {o_lcd.rs, o_lcd.data}",
                                                   r, i), exp_q[i], seen_q[i]);
            end
        end
    endtask

    initial begin
        int r;
        start = 1'b0;
        mode = '0;
        rst_req = 1'b0;
        load_table();
        @(posedge clk);
        @(negedge clk);
        check_reset_state();
        wait_reset_release(16);
        check_init_sequence();
        for (r = 0; r < N_ROWS; r++) begin
            run_row(r);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- compile.f
+incdir+.
lcd_pkg.sv
lcd_msg_rom.sv
lcd_cmd_engine.sv
lcd_data_engine.sv
lcd_ctrl.sv
tb_clk_gen.sv
lcd_assertions.sv
tb_lcd.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_lcd -f compile.f -o tb_lcd
	@out="$$(./obj_dir/tb_lcd)"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
